// ==== vlog.f ====
+incdir+verif
source/ppu_pkg.sv
source/ppu_regs_pkg.sv
source/posit_special_handler.sv
source/posit_decoder.sv
source/posit_arith_core.sv
source/posit_result_stage.sv
source/ppu_axil_top.sv
verif/ppu_tb.sv

// ==== Bender.yml ====
package:
  name: ppu

dependencies: {}

sources:
  - files:
      - source/ppu_pkg.sv
      - source/ppu_regs_pkg.sv
      - source/posit_special_handler.sv
      - source/posit_decoder.sv
      - source/posit_arith_core.sv
      - source/posit_result_stage.sv
      - source/ppu_axil_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/ppu_tb.sv

// ==== verif/ppu_tests.svh ====
localparam int NOT_EXACT = 9999;
localparam logic [AXIL_ADDR_W-1:0] UNMAPPED_ADDR = 5'h14;

function automatic logic [PPU_N-1:0] special_expected(input operation_e op,
                                                       input logic [PPU_N-1:0] a,
                                                       input logic [PPU_N-1:0] b);
  logic [PPU_N-1:0] neg_b;
  neg_b = -b;
  if (a == NAR_POSIT || b == NAR_POSIT) begin
    return NAR_POSIT;
  end
  case (op)
    ADD: return (a == '0) ? b : a;
    SUB: return (b == '0) ? a : neg_b;
    MUL: return '0;
    default: return (b == '0) ? NAR_POSIT : '0;
  endcase
endfunction

// table values are kept in halves, so every exact result stays an integer.
function automatic int table_halves(input int idx);
  int mag;
  case (idx % 6)
    0: mag = 1;
    1: mag = 2;
    2: mag = 3;
    3: mag = 4;
    4: mag = 6;
    default: mag = 8;
  endcase
  return (idx < 6) ? mag : -mag;
endfunction

function automatic logic [PPU_N-1:0] table_posit(input int idx);
  logic [PPU_N-1:0] mag;
  case (idx % 6)
    0: mag = 8'h20;
    1: mag = 8'h40;
    2: mag = 8'h50;
    3: mag = 8'h60;
    4: mag = 8'h68;
    default: mag = 8'h70;
  endcase
  return (idx < 6) ? mag : -mag;
endfunction

function automatic int exact_halves(input operation_e op, input int a, input int b);
  case (op)
    ADD: return a + b;
    SUB: return a - b;
    MUL: return ((a * b) % 2 == 0) ? (a * b) / 2 : NOT_EXACT;
    default: return ((2 * a) % b == 0) ? (2 * a) / b : NOT_EXACT;
  endcase
endfunction

function automatic int table_index(input int halves);
  for (int i = 0; i < 12; i++) begin
    if (table_halves(i) == halves) begin
      return i;
    end
  end
  return -1;
endfunction

// partners are fully random, so zero and NaR meet each other too.
task automatic special_table_test();
  logic [PPU_N-1:0] special_val;
  logic [PPU_N-1:0] other;
  logic [PPU_N-1:0] a;
  logic [PPU_N-1:0] b;
  logic [PPU_N-1:0] got;
  operation_e op;
  for (int o = 0; o < 4; o++) begin
    op = operation_e'(o);
    for (int s = 0; s < 2; s++) begin
      special_val = (s == 0) ? '0 : NAR_POSIT;
      for (int side = 0; side < 2; side++) begin
        for (int k = 0; k < SPECIAL_PARTNERS; k++) begin
          other = PPU_N'($urandom);
          a = (side == 0) ? special_val : other;
          b = (side == 0) ? other : special_val;
          run_op(op, a, b, got);
          check_posit($sformatf("special %s result", op.name()), got,
                      special_expected(op, a, b));
        end
      end
    end
  end
endtask

task automatic exact_arith_test();
  int res_halves;
  int k;
  logic [PPU_N-1:0] got;
  operation_e op;
  for (int o = 0; o < 4; o++) begin
    op = operation_e'(o);
    for (int i = 0; i < 12; i++) begin
      for (int j = 0; j < 12; j++) begin
        res_halves = exact_halves(op, table_halves(i), table_halves(j));
        k = table_index(res_halves);
        if (k >= 0) begin
          run_op(op, table_posit(i), table_posit(j), got);
          check_posit($sformatf("exact %s result", op.name()), got, table_posit(k));
        end
      end
    end
  end
endtask

task automatic identity_test();
  logic [PPU_N-1:0] x;
  logic [PPU_N-1:0] neg_x;
  logic [PPU_N-1:0] got;
  for (int r = 0; r < IDENTITY_ROUNDS; r++) begin
    do begin
      x = PPU_N'($urandom);
    end while (x == '0 || x == NAR_POSIT);
    neg_x = -x;
    run_op(MUL, x, ONE_POSIT, got);
    check_posit("x*1 result", got, x);
    run_op(DIV, x, ONE_POSIT, got);
    check_posit("x/1 result", got, x);
    run_op(SUB, x, x, got);
    check_posit("x-x result", got, '0);
    run_op(ADD, x, neg_x, got);
    check_posit("x+(-x) result", got, '0);
  end
endtask

task automatic saturation_test();
  logic [PPU_N-1:0] got;
  run_op(MUL, MAXPOS, MAXPOS, got);
  check_posit("maxpos*maxpos result", got, MAXPOS);
  run_op(MUL, MINPOS, MINPOS, got);
  check_posit("minpos*minpos result", got, MINPOS);
endtask

task automatic bus_test();
  logic [AXIL_DATA_W-1:0] data;
  logic [1:0] resp;
  logic [PPU_N-1:0] val_a;
  logic [PPU_N-1:0] val_b;
  // done is still set by the last operation, so the count also covers its clear.
  write_reg(REG_OPERATION, AXIL_DATA_W'(ADD), resp);
  check_resp("bresp of REG_OPERATION", resp, RESP_OKAY);
  do begin
    @(posedge clk);
  end while (!ppu_axil_top_i.done && (cycle_count - last_write_cycle) < 10);
  check_cycles("done latency in cycles", cycle_count - last_write_cycle, 3);
  write_reg(REG_RESULT, $urandom, resp);
  check_resp("bresp of REG_RESULT write", resp, RESP_SLVERR);
  write_reg(UNMAPPED_ADDR, $urandom, resp);
  check_resp("bresp of unmapped write", resp, RESP_SLVERR);
  val_a = PPU_N'($urandom);
  val_b = PPU_N'($urandom);
  write_reg(REG_OPERAND_A, AXIL_DATA_W'(val_a), resp);
  check_resp("bresp of REG_OPERAND_A", resp, RESP_OKAY);
  write_reg(REG_OPERAND_B, AXIL_DATA_W'(val_b), resp);
  check_resp("bresp of REG_OPERAND_B", resp, RESP_OKAY);
  read_reg(REG_OPERAND_A, data, resp);
  check_resp("rresp of REG_OPERAND_A", resp, RESP_OKAY);
  check_posit("REG_OPERAND_A readback", data[PPU_N-1:0], val_a);
  read_reg(REG_OPERAND_B, data, resp);
  check_resp("rresp of REG_OPERAND_B", resp, RESP_OKAY);
  check_posit("REG_OPERAND_B readback", data[PPU_N-1:0], val_b);
endtask

// ==== verif/ppu_tb.sv ====
`timescale 1ns/1ns

module ppu_tb
  import ppu_pkg::*;
  import ppu_regs_pkg::*;
();

  localparam int RESET_CYCLES = 16;
  localparam int CYCLES_PER_OP = 20;
  localparam int SPECIAL_PARTNERS = 32;
  localparam int IDENTITY_ROUNDS = 16;
  localparam int DONE_POLL_LIMIT = 8;
  // the exact test runs at most one operation per table pair and opcode.
  localparam int NUM_OPS = 16 * SPECIAL_PARTNERS + 4 * 12 * 12 + 4 * IDENTITY_ROUNDS + 2 + 6;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + CYCLES_PER_OP * NUM_OPS;
  localparam int RAND_SEED = 32'h7c99_6f73;

  localparam logic [PPU_N-1:0] NAR_POSIT = {1'b1, {(PPU_N-1){1'b0}}};
  localparam logic [PPU_N-1:0] ONE_POSIT = {2'b01, {(PPU_N-2){1'b0}}};
  localparam logic [PPU_N-1:0] MAXPOS = {1'b0, {(PPU_N-1){1'b1}}};
  localparam logic [PPU_N-1:0] MINPOS = PPU_N'(1);

  logic clk;
  logic rst_n;
  logic [AXIL_ADDR_W-1:0] awaddr;
  logic awvalid;
  logic awready;
  logic [AXIL_DATA_W-1:0] wdata;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  logic [AXIL_ADDR_W-1:0] araddr;
  logic arvalid;
  logic arready;
  logic [AXIL_DATA_W-1:0] rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;

  int cycle_count;
  int last_write_cycle;

  ppu_axil_top #(
    .N  (PPU_N),
    .ES (PPU_ES)
  ) ppu_axil_top_i (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bresp_o   (bresp),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_araddr_i  (araddr),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "run stopped at the first error");
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  task automatic check_posit(input string name, input logic [PPU_N-1:0] actual,
                             input logic [PPU_N-1:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("MISMATCH at %0t: %s expected %h, got %h",
                         $time, name, expected, actual));
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] actual,
                            input logic [1:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("MISMATCH at %0t: %s expected %b, got %b",
                         $time, name, expected, actual));
    end
  endtask

  task automatic check_cycles(input string name, input int actual, input int expected);
    if (actual != expected) begin
      fail_run($sformatf("MISMATCH at %0t: %s expected %0d, got %0d",
                         $time, name, expected, actual));
    end
  endtask

  // every bus task starts and ends just after a rising edge.
  task automatic write_reg(input logic [AXIL_ADDR_W-1:0] addr,
                           input logic [AXIL_DATA_W-1:0] data, output logic [1:0] resp);
    awaddr <= addr;
    wdata <= data;
    awvalid <= 1'b1;
    wvalid <= 1'b1;
    do begin
      @(posedge clk);
    end while (!(awready && wready));
    last_write_cycle = cycle_count;
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    bready <= 1'b1;
    do begin
      @(posedge clk);
    end while (!bvalid);
    resp = bresp;
    bready <= 1'b0;
  endtask

  task automatic read_reg(input logic [AXIL_ADDR_W-1:0] addr,
                          output logic [AXIL_DATA_W-1:0] data, output logic [1:0] resp);
    araddr <= addr;
    arvalid <= 1'b1;
    do begin
      @(posedge clk);
    end while (!arready);
    arvalid <= 1'b0;
    rready <= 1'b1;
    do begin
      @(posedge clk);
    end while (!rvalid);
    data = rdata;
    resp = rresp;
    rready <= 1'b0;
  endtask

  task automatic wait_done();
    logic [AXIL_DATA_W-1:0] data;
    logic [1:0] resp;
    int polls;
    polls = 0;
    do begin
      read_reg(REG_STATUS, data, resp);
      check_resp("rresp of REG_STATUS", resp, RESP_OKAY);
      polls++;
    end while (!data[STATUS_DONE_BIT] && polls < DONE_POLL_LIMIT);
    if (!data[STATUS_DONE_BIT]) begin
      fail_run($sformatf("done was never set within %0d status reads", DONE_POLL_LIMIT));
    end
  endtask

  task automatic run_op(input operation_e op, input logic [PPU_N-1:0] a,
                        input logic [PPU_N-1:0] b, output logic [PPU_N-1:0] result);
    logic [AXIL_DATA_W-1:0] data;
    logic [1:0] resp;
    write_reg(REG_OPERAND_A, AXIL_DATA_W'(a), resp);
    check_resp("bresp of REG_OPERAND_A", resp, RESP_OKAY);
    write_reg(REG_OPERAND_B, AXIL_DATA_W'(b), resp);
    check_resp("bresp of REG_OPERAND_B", resp, RESP_OKAY);
    write_reg(REG_OPERATION, AXIL_DATA_W'(op), resp);
    check_resp("bresp of REG_OPERATION", resp, RESP_OKAY);
    wait_done();
    read_reg(REG_RESULT, data, resp);
    check_resp("rresp of REG_RESULT", resp, RESP_OKAY);
    result = data[PPU_N-1:0];
  endtask

  `include "ppu_tests.svh"

  initial begin
    void'($urandom(RAND_SEED));
    rst_n = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    repeat (RESET_CYCLES) begin
      @(posedge clk);
    end
    rst_n <= 1'b1;
    @(posedge clk);
    special_table_test();
    exact_arith_test();
    identity_test();
    saturation_test();
    bus_test();
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== source/ppu_axil_top.sv ====
`timescale 1ns/1ns

module ppu_axil_top
  import ppu_pkg::*;
  import ppu_regs_pkg::*;
#(
  parameter int N = PPU_N,
  parameter int ES = PPU_ES
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic [AXIL_ADDR_W-1:0]  s_axil_awaddr_i,
  input  logic                    s_axil_awvalid_i,
  output logic                    s_axil_awready_o,
  input  logic [AXIL_DATA_W-1:0]  s_axil_wdata_i,
  input  logic                    s_axil_wvalid_i,
  output logic                    s_axil_wready_o,
  output logic [1:0]              s_axil_bresp_o,
  output logic                    s_axil_bvalid_o,
  input  logic                    s_axil_bready_i,
  input  logic [AXIL_ADDR_W-1:0]  s_axil_araddr_i,
  input  logic                    s_axil_arvalid_i,
  output logic                    s_axil_arready_o,
  output logic [AXIL_DATA_W-1:0]  s_axil_rdata_o,
  output logic [1:0]              s_axil_rresp_o,
  output logic                    s_axil_rvalid_o,
  input  logic                    s_axil_rready_i
);

  logic wr_fire;
  logic wr_ok;
  logic rd_fire;
  logic rd_ok;
  logic [AXIL_DATA_W-1:0] rd_data;
  logic [AXIL_DATA_W-1:0] status_word;

  logic [N-1:0] operand_a_q;
  logic [N-1:0] operand_b_q;
  operation_e operation_q;
  logic start_q;

  logic special;
  logic [N-1:0] special_posit;
  logic core_valid;
  logic core_sign;
  logic signed [PPU_SCALE_W-1:0] core_scale;
  logic [2*N-1:0] core_frac;
  logic core_sticky;
  logic [N-1:0] result;
  logic done;

  assign wr_fire = s_axil_awready_o & s_axil_awvalid_i & s_axil_wready_o & s_axil_wvalid_i;
  assign wr_ok = (s_axil_awaddr_i == REG_OPERAND_A) || (s_axil_awaddr_i == REG_OPERAND_B) ||
                 (s_axil_awaddr_i == REG_OPERATION);
  assign rd_fire = s_axil_arready_o & s_axil_arvalid_i;

  // AW and W are taken together, and only while no B response is waiting.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s_axil_awready_o <= 1'b0;
      s_axil_wready_o <= 1'b0;
      s_axil_bvalid_o <= 1'b0;
      start_q <= 1'b0;
    end else begin
      s_axil_awready_o <= !s_axil_awready_o && s_axil_awvalid_i && s_axil_wvalid_i &&
                          !s_axil_bvalid_o;
      s_axil_wready_o <= !s_axil_awready_o && s_axil_awvalid_i && s_axil_wvalid_i &&
                         !s_axil_bvalid_o;
      start_q <= wr_fire && (s_axil_awaddr_i == REG_OPERATION);
      if (wr_fire) begin
        s_axil_bvalid_o <= 1'b1;
      end else if (s_axil_bready_i) begin
        s_axil_bvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      s_axil_bresp_o <= wr_ok ? RESP_OKAY : RESP_SLVERR;
      case (s_axil_awaddr_i)
        REG_OPERAND_A: operand_a_q <= s_axil_wdata_i[N-1:0];
        REG_OPERAND_B: operand_b_q <= s_axil_wdata_i[N-1:0];
        REG_OPERATION: operation_q <= operation_e'(s_axil_wdata_i[1:0]);
        default: ;
      endcase
    end
  end

  always_comb begin
    status_word = '0;
    status_word[STATUS_DONE_BIT] = done;
    rd_ok = 1'b1;
    case (s_axil_araddr_i)
      REG_OPERAND_A: rd_data = AXIL_DATA_W'(operand_a_q);
      REG_OPERAND_B: rd_data = AXIL_DATA_W'(operand_b_q);
      REG_OPERATION: rd_data = AXIL_DATA_W'(operation_q);
      REG_RESULT: rd_data = AXIL_DATA_W'(result);
      REG_STATUS: rd_data = status_word;
      default: begin
        rd_data = '0;
        rd_ok = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s_axil_arready_o <= 1'b0;
      s_axil_rvalid_o <= 1'b0;
    end else begin
      s_axil_arready_o <= !s_axil_arready_o && s_axil_arvalid_i && !s_axil_rvalid_o;
      if (rd_fire) begin
        s_axil_rvalid_o <= 1'b1;
      end else if (s_axil_rready_i) begin
        s_axil_rvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      s_axil_rdata_o <= rd_data;
      s_axil_rresp_o <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  posit_special_handler #(
    .N (N)
  ) special_handler_i (
    .op_i      (operation_q),
    .p1_i      (operand_a_q),
    .p2_i      (operand_b_q),
    .special_o (special),
    .pout_o    (special_posit)
  );

  posit_arith_core #(
    .N  (N),
    .ES (ES)
  ) arith_core_i (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .start_i  (start_q),
    .op_i     (operation_q),
    .p1_i     (operand_a_q),
    .p2_i     (operand_b_q),
    .valid_o  (core_valid),
    .sign_o   (core_sign),
    .scale_o  (core_scale),
    .frac_o   (core_frac),
    .sticky_o (core_sticky)
  );

  posit_result_stage #(
    .N  (N),
    .ES (ES)
  ) result_stage_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .start_i         (start_q),
    .valid_i         (core_valid),
    .sign_i          (core_sign),
    .scale_i         (core_scale),
    .frac_i          (core_frac),
    .sticky_i        (core_sticky),
    .special_i       (special),
    .special_posit_i (special_posit),
    .result_o        (result),
    .done_o          (done)
  );

endmodule

// ==== source/posit_result_stage.sv ====
`timescale 1ns/1ns

module posit_result_stage
  import ppu_pkg::*;
#(
  parameter int N = PPU_N,
  parameter int ES = PPU_ES
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           start_i,
  input  logic                           valid_i,
  input  logic                           sign_i,
  input  logic signed [PPU_SCALE_W-1:0]  scale_i,
  input  logic [2*N-1:0]                 frac_i,
  input  logic                           sticky_i,
  input  logic                           special_i,
  input  logic [N-1:0]                   special_posit_i,
  output logic [N-1:0]                   result_o,
  output logic                           done_o
);

  localparam int TW = 2 * N - 1 + ES;
  localparam int LW = 3 * N + ES;
  localparam int MAX_SCALE = (N - 2) * (2 ** ES);

  logic special_q;
  logic [N-1:0] special_posit_q;

  int scale_c;
  int regime;
  int exp_val;
  int reg_len;
  int cut;
  logic [TW-1:0] tail;
  logic [LW-1:0] bits;
  logic [LW-1:0] low_mask;
  logic [N-2:0] body;
  logic guard;
  logic round_up;
  logic [N-1:0] mag;
  logic [N-1:0] core_posit;

  always_comb begin
    // out-of-range scales saturate below, clamping keeps the bit string in range.
    scale_c = int'(scale_i);
    if (scale_c > MAX_SCALE) begin
      scale_c = MAX_SCALE;
    end else if (scale_c < -MAX_SCALE) begin
      scale_c = -MAX_SCALE;
    end
    regime = scale_c >>> ES;
    exp_val = scale_c - regime * (2 ** ES);

    if (regime >= 0) begin
      reg_len = regime + 2;
      bits = ((LW'(1) << (regime + 1)) - 1'b1) << 1;
    end else begin
      reg_len = 1 - regime;
      bits = LW'(1);
    end
    tail = (TW'(exp_val) << (2 * N - 1)) | TW'(frac_i[2*N-2:0]);
    bits = (bits << TW) | LW'(tail);

    // keep the top N-1 bits, round the rest to nearest even.
    cut = reg_len + TW - (N - 1);
    body = (N-1)'(bits >> cut);
    guard = bits[cut-1];
    low_mask = (LW'(1) << (cut - 1)) - 1'b1;
    round_up = guard & (((bits & low_mask) != '0) | sticky_i | body[0]);
    mag = {1'b0, body} + N'(round_up);

    if (int'(scale_i) >= MAX_SCALE) begin
      mag = {1'b0, {(N-1){1'b1}}};
    end else if (int'(scale_i) < -MAX_SCALE) begin
      mag = N'(1);
    end

    if (!frac_i[2*N-1]) begin
      core_posit = '0;
    end else if (sign_i) begin
      core_posit = N'(c2(PPU_MAX_W'(mag), N));
    end else begin
      core_posit = mag;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      special_q <= special_i;
      special_posit_q <= special_posit_i;
    end
    if (valid_i) begin
      result_o <= special_q ? special_posit_q : core_posit;
    end
  end

  // a new start hides the older result still in flight.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_o <= 1'b0;
    end else if (start_i) begin
      done_o <= 1'b0;
    end else if (valid_i) begin
      done_o <= 1'b1;
    end
  end

endmodule

// ==== source/posit_arith_core.sv ====
`timescale 1ns/1ns

module posit_arith_core
  import ppu_pkg::*;
#(
  parameter int N = PPU_N,
  parameter int ES = PPU_ES
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           start_i,
  input  operation_e                     op_i,
  input  logic [N-1:0]                   p1_i,
  input  logic [N-1:0]                   p2_i,
  output logic                           valid_o,
  output logic                           sign_o,
  output logic signed [PPU_SCALE_W-1:0]  scale_o,
  output logic [2*N-1:0]                 frac_o,
  output logic                           sticky_o
);

  localparam int FW = N - 1;
  localparam int MW = 2 * N;
  localparam int QW = 3 * N - 2;

  logic sign1;
  logic sign2;
  logic signed [PPU_SCALE_W-1:0] scale1;
  logic signed [PPU_SCALE_W-1:0] scale2;
  logic [FW-1:0] frac1;
  logic [FW-1:0] frac2;

  logic swap;
  logic sign2_eff;
  logic same_sign;
  logic big_sign;
  int big_scale;
  int shift_amt;
  logic [MW-1:0] big_ext;
  logic [MW-1:0] small_ext;
  logic [MW-1:0] small_al;
  logic align_sticky;
  logic [MW-1:0] sum;

  logic [2*FW-1:0] prod;

  logic [QW-1:0] dividend;
  logic [QW-1:0] quot;
  logic [N-1:0] rem;
  logic div_sticky;

  logic [MW-1:0] mant;
  int mant_scale;
  logic res_sign;
  logic res_sticky;
  int lead;
  logic [MW-1:0] norm_frac;
  int norm_scale;

  posit_decoder #(
    .N  (N),
    .ES (ES)
  ) decoder_p1_i (
    .p_i     (p1_i),
    .sign_o  (sign1),
    .scale_o (scale1),
    .frac_o  (frac1)
  );

  posit_decoder #(
    .N  (N),
    .ES (ES)
  ) decoder_p2_i (
    .p_i     (p2_i),
    .sign_o  (sign2),
    .scale_o (scale2),
    .frac_o  (frac2)
  );

  // add and sub share one magnitude adder; the larger operand stays put.
  always_comb begin
    sign2_eff = sign2 ^ (op_i == SUB);
    same_sign = (sign1 == sign2_eff);
    swap = (scale2 > scale1) || ((scale2 == scale1) && (frac2 > frac1));
    big_sign = swap ? sign2_eff : sign1;
    big_scale = swap ? int'(scale2) : int'(scale1);
    shift_amt = swap ? int'(scale2) - int'(scale1) : int'(scale1) - int'(scale2);
    big_ext = {1'b0, (swap ? frac2 : frac1), {N{1'b0}}};
    small_ext = {1'b0, (swap ? frac1 : frac2), {N{1'b0}}};
    small_al = small_ext >> shift_amt;
    align_sticky = ((small_al << shift_amt) != small_ext);
    if (same_sign) begin
      sum = big_ext + small_al;
    end else begin
      // shifted-out bits make the true difference slightly smaller.
      sum = big_ext - small_al - MW'(align_sticky);
    end
  end

  assign prod = frac1 * frac2;

  assign dividend = {frac1, {(2*N-1){1'b0}}};

  always_comb begin
    rem = '0;
    quot = '0;
    for (int i = QW - 1; i >= 0; i--) begin
      rem = {rem[N-2:0], dividend[i]};
      if (rem >= {1'b0, frac2}) begin
        rem = rem - {1'b0, frac2};
        quot[i] = 1'b1;
      end
    end
    div_sticky = (rem != '0);
  end

  // mant holds 1.0 at bit MW-1 for scale mant_scale.
  always_comb begin
    case (op_i)
      ADD, SUB: begin
        mant = sum;
        mant_scale = big_scale + 1;
        res_sign = (sum == '0) ? 1'b0 : big_sign;
        res_sticky = align_sticky;
      end
      MUL: begin
        mant = {prod, 2'b00};
        mant_scale = int'(scale1) + int'(scale2) + 1;
        res_sign = sign1 ^ sign2;
        res_sticky = 1'b0;
      end
      default: begin
        mant = quot[MW-1:0];
        mant_scale = int'(scale1) - int'(scale2);
        res_sign = sign1 ^ sign2;
        res_sticky = div_sticky;
      end
    endcase

    lead = 0;
    for (int i = 0; i < MW; i++) begin
      if (mant[i]) begin
        lead = i;
      end
    end
    norm_frac = mant << (MW - 1 - lead);
    norm_scale = mant_scale - (MW - 1 - lead);
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= start_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      sign_o <= res_sign;
      scale_o <= PPU_SCALE_W'(norm_scale);
      frac_o <= norm_frac;
      sticky_o <= res_sticky;
    end
  end

endmodule

// ==== source/posit_decoder.sv ====
`timescale 1ns/1ns

module posit_decoder
  import ppu_pkg::*;
#(
  parameter int N = PPU_N,
  parameter int ES = PPU_ES
) (
  input  logic [N-1:0]                   p_i,
  output logic                           sign_o,
  output logic signed [PPU_SCALE_W-1:0]  scale_o,
  output logic [N-2:0]                   frac_o
);

  logic [N-1:0] abs_p;
  logic [N-2:0] body;
  logic [N-2:0] rem_bits;
  logic [N-2:0] frac_bits;
  int run_len;
  int regime;
  int exp_val;

  assign sign_o = p_i[N-1];
  assign abs_p = sign_o ? N'(c2(PPU_MAX_W'(p_i), N)) : p_i;
  assign body = abs_p[N-2:0];

  always_comb begin
    logic in_run;
    run_len = 0;
    in_run = 1'b1;
    for (int i = N - 2; i >= 0; i--) begin
      if (in_run && (body[i] == body[N-2])) begin
        run_len++;
      end else begin
        in_run = 1'b0;
      end
    end
    regime = body[N-2] ? run_len - 1 : -run_len;

    // drop the regime run and its terminating bit.
    rem_bits = body << (run_len + 1);
    exp_val = int'(rem_bits >> (N - 1 - ES));
    frac_bits = rem_bits << ES;

    scale_o = PPU_SCALE_W'(regime * (2 ** ES) + exp_val);
    // the lowest bit of frac_bits is always zero, so nothing is lost here.
    frac_o = {1'b1, frac_bits[N-2:1]};
  end

endmodule

// ==== source/posit_special_handler.sv ====
`timescale 1ns/1ns

module posit_special_handler
  import ppu_pkg::*;
#(
  parameter int N = PPU_N
) (
  input  operation_e       op_i,
  input  logic [N-1:0]     p1_i,
  input  logic [N-1:0]     p2_i,
  output logic             special_o,
  output logic [N-1:0]     pout_o
);

  localparam logic [N-1:0] NAR = {1'b1, {(N-1){1'b0}}};

  logic zero1;
  logic zero2;
  logic nar1;
  logic nar2;
  logic nar_any;
  logic [N-1:0] neg_p2;

  assign zero1 = is_zero(PPU_MAX_W'(p1_i), N);
  assign zero2 = is_zero(PPU_MAX_W'(p2_i), N);
  assign nar1 = is_nar(PPU_MAX_W'(p1_i), N);
  assign nar2 = is_nar(PPU_MAX_W'(p2_i), N);
  assign nar_any = nar1 | nar2;
  assign neg_p2 = N'(c2(PPU_MAX_W'(p2_i), N));

  assign special_o = zero1 | zero2 | nar_any;

  // only meaningful while special_o is high, so at least one operand is zero or NaR here.
  always_comb begin
    case (op_i)
      ADD: begin
        if (nar_any) begin
          pout_o = NAR;
        end else if (zero1) begin
          pout_o = p2_i;
        end else begin
          pout_o = p1_i;
        end
      end
      SUB: begin
        if (nar_any) begin
          pout_o = NAR;
        end else if (zero2) begin
          pout_o = p1_i;
        end else begin
          // zero minus x.
          pout_o = neg_p2;
        end
      end
      MUL: begin
        pout_o = nar_any ? NAR : '0;
      end
      default: begin
        // div: anything over zero is NaR, zero over a regular posit is zero.
        pout_o = (nar_any || zero2) ? NAR : '0;
      end
    endcase
  end

endmodule

// ==== source/ppu_regs_pkg.sv ====
package ppu_regs_pkg;

  localparam int AXIL_ADDR_W = 5;
  localparam int AXIL_DATA_W = 32;

  // one 32-bit word per register.
  localparam logic [AXIL_ADDR_W-1:0] REG_OPERAND_A = 5'h00;
  localparam logic [AXIL_ADDR_W-1:0] REG_OPERAND_B = 5'h04;
  localparam logic [AXIL_ADDR_W-1:0] REG_OPERATION = 5'h08;
  localparam logic [AXIL_ADDR_W-1:0] REG_RESULT = 5'h0C;
  localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 5'h10;

  localparam int STATUS_DONE_BIT = 0;

  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== source/ppu_pkg.sv ====
package ppu_pkg;

  localparam int PPU_N = 8;
  localparam int PPU_ES = 0;
  localparam int PPU_SCALE_W = 6;

  // the helper functions below work on this width; the caller passes its own posit width.
  localparam int PPU_MAX_W = 32;

  typedef enum logic [1:0] {
    ADD = 2'd0,
    SUB = 2'd1,
    MUL = 2'd2,
    DIV = 2'd3
  } operation_e;

  function automatic logic [PPU_MAX_W-1:0] width_mask(input int unsigned n);
    return (n >= PPU_MAX_W) ? '1 : ((PPU_MAX_W'(1) << n) - 1'b1);
  endfunction

  function automatic logic is_zero(input logic [PPU_MAX_W-1:0] p, input int unsigned n);
    return (p & width_mask(n)) == '0;
  endfunction

  // NaR is the sign bit alone.
  function automatic logic is_nar(input logic [PPU_MAX_W-1:0] p, input int unsigned n);
    return (p & width_mask(n)) == (PPU_MAX_W'(1) << (n - 1));
  endfunction

  function automatic logic [PPU_MAX_W-1:0] c2(input logic [PPU_MAX_W-1:0] p,
                                              input int unsigned n);
    return (~p + 1'b1) & width_mask(n);
  endfunction

endpackage
